//--- logic/memory_game_consts.svh
`ifndef MEMORY_GAME_CONSTS_SVH
`define MEMORY_GAME_CONSTS_SVH

// Small VGA frame, sync pulses active high
`define H_ACTIVE     64
`define H_SYNC_START 68
`define H_SYNC_END   72
`define H_TOTAL      80
`define V_ACTIVE     48
`define V_SYNC_START 49
`define V_SYNC_END   51
`define V_TOTAL      52

// Board of 4 x 4 cards
`define CARD_COLS 4
`define CARD_ROWS 4
`define CARD_W    12
`define CARD_H    8
`define CARD_GAP  2
`define BOARD_X   4
`define BOARD_Y   4

// Frames a mismatched pair stays face up
`define SHOW_FRAMES 2

// Shuffle LFSR, taps 16 14 13 11
`define DEAL_SEED 16'hACE1
`define LFSR_TAPS 16'hB400

`endif

//--- logic/memory_game_pkg.sv
package memory_game_pkg;

    typedef logic [3:0] card_addr_t;
    typedef logic [2:0] color_idx_t;

    typedef enum logic [1:0] {
        CARD_HIDDEN  = 2'd0,
        CARD_SHOWN   = 2'd1,
        CARD_MATCHED = 2'd2
    } card_state_t;

    // One board slot
    typedef struct packed {
        color_idx_t  color;
        card_state_t state;
    } card_t;

    // 4 bits each for red, green, blue
    typedef logic [11:0] rgb_t;

    localparam rgb_t CARD_PALETTE [0:7] = '{
        12'hF00,
        12'h0F0,
        12'h00F,
        12'hFF0,
        12'hF0F,
        12'h0FF,
        12'hF80,
        12'hFFF
    };

    // Card back and table
    localparam rgb_t HIDDEN_RGB     = 12'h888;
    localparam rgb_t BACKGROUND_RGB = 12'h153;

endpackage

//--- logic/vga_bus_if.sv
`timescale 1ns/100ps

interface vga_bus_if;
    import memory_game_pkg::*;

    logic [10:0] hcount;
    logic [10:0] vcount;
    logic        hsync;
    logic        vsync;
    logic        hblnk;
    logic        vblnk;
    rgb_t        rgb;

    // Timing generator side
    modport src (output hcount, vcount, hsync, vsync, hblnk, vblnk, rgb);

    // Drawing side
    modport snk (input hcount, vcount, hsync, vsync, hblnk, vblnk, rgb);

endinterface

//--- logic/vga_timing.sv
`timescale 1ns/100ps

`include "memory_game_consts.svh"

module vga_timing (
    input  logic      clk,
    input  logic      rst_n,
    vga_bus_if.src    vga
);
    import memory_game_pkg::*;

    logic [10:0] hcnt;
    logic [10:0] vcnt;

    //////////////////////////////
    // Pixel and line counters
    //////////////////////////////

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            hcnt <= '0;
            vcnt <= '0;
        end else if (hcnt == `H_TOTAL - 1) begin
            hcnt <= '0;
            if (vcnt == `V_TOTAL - 1) begin
                vcnt <= '0;
            end else begin
                vcnt <= vcnt + 11'd1;
            end
        end else begin
            hcnt <= hcnt + 11'd1;
        end
    end

    //////////////////////////////
    // Sync and blanking decode
    //////////////////////////////

    assign vga.hcount = hcnt;
    assign vga.vcount = vcnt;

    // End of each sync window is exclusive
    assign vga.hsync = (hcnt >= `H_SYNC_START) && (hcnt < `H_SYNC_END);
    assign vga.vsync = (vcnt >= `V_SYNC_START) && (vcnt < `V_SYNC_END);

    assign vga.hblnk = (hcnt >= `H_ACTIVE);
    assign vga.vblnk = (vcnt >= `V_ACTIVE);

    // Plain table, cards are painted on top later
    assign vga.rgb = BACKGROUND_RGB;

endmodule

//--- logic/card_deal.sv
`timescale 1ns/100ps

`include "memory_game_consts.svh"

module card_deal (
    input  logic                        clk,
    input  logic                        rst_n,
    input  logic                        deal_req,
    output logic                        deal_ack,
    output logic                        deal_we,
    output memory_game_pkg::card_addr_t deal_addr,
    output memory_game_pkg::card_t      deal_data
);
    import memory_game_pkg::*;

    typedef enum logic [2:0] {
        IDLE,
        INIT,
        SHUFFLE,
        WRITE,
        ACK
    } deal_state_t;

    deal_state_t state;
    card_addr_t  cnt;
    logic [15:0] lfsr;
    logic [15:0] lfsr_next;
    card_addr_t  swap_idx;
    color_idx_t  board [16];

    // Fibonacci LFSR, shifts left
    assign lfsr_next = {lfsr[14:0], ^(lfsr & `LFSR_TAPS)};
    assign swap_idx  = lfsr_next[3:0];

    //////////////////////////////
    // Sequencer
    //////////////////////////////

    // cnt walks 15 down to 0 for the shuffle and again for write-out
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state <= IDLE;
            cnt   <= '0;
        end else begin
            case (state)
                IDLE: begin
                    if (deal_req) begin
                        state <= INIT;
                    end
                end
                INIT: begin
                    cnt   <= 4'd15;
                    state <= SHUFFLE;
                end
                SHUFFLE: begin
                    cnt <= cnt - 4'd1;
                    if (cnt == 4'd0) begin
                        state <= WRITE;
                    end
                end
                WRITE: begin
                    cnt <= cnt - 4'd1;
                    if (cnt == 4'd0) begin
                        state <= ACK;
                    end
                end
                ACK: begin
                    if (!deal_req) begin
                        state <= IDLE;
                    end
                end
                default: state <= IDLE;
            endcase
        end
    end

    //////////////////////////////
    // Local board and shuffle
    //////////////////////////////

    always_ff @(posedge clk) begin
        if (state == INIT) begin
            lfsr <= `DEAL_SEED;
            // Pairs in order, slot i gets colour i/2
            for (int i = 0; i < 16; i++) begin
                board[i] <= color_idx_t'(i >> 1);
            end
        end else if (state == SHUFFLE) begin
            lfsr            <= lfsr_next;
            board[cnt]      <= board[swap_idx];
            board[swap_idx] <= board[cnt];
        end
    end

    assign deal_we   = (state == WRITE);
    assign deal_addr = cnt;
    assign deal_data = '{color: board[cnt], state: CARD_HIDDEN};
    assign deal_ack  = (state == ACK);

endmodule

//--- logic/card_store.sv
`timescale 1ns/100ps

module card_store (
    input  logic                        clk,

    // Dealer write port, wins on a clash
    input  logic                        deal_we,
    input  memory_game_pkg::card_addr_t deal_addr,
    input  memory_game_pkg::card_t      deal_data,

    // Game write port
    input  logic                        game_we,
    input  memory_game_pkg::card_addr_t game_addr,
    input  memory_game_pkg::card_t      game_data,

    // Pixel read port
    input  memory_game_pkg::card_addr_t rd_a_addr,
    output memory_game_pkg::card_t      rd_a_data,

    // Game read port
    input  memory_game_pkg::card_addr_t rd_b_addr,
    output memory_game_pkg::card_t      rd_b_data
);

    memory_game_pkg::card_t cards [16];

    always_ff @(posedge clk) begin
        if (deal_we) begin
            cards[deal_addr] <= deal_data;
        end else if (game_we) begin
            cards[game_addr] <= game_data;
        end
    end

    // Both reads see the array as it is
    assign rd_a_data = cards[rd_a_addr];
    assign rd_b_data = cards[rd_b_addr];

endmodule

//--- logic/game_fsm.sv
`timescale 1ns/100ps

`include "memory_game_consts.svh"

module game_fsm (
    input  logic                        clk,
    input  logic                        rst_n,
    input  logic                        vsync,
    input  logic                        click,
    input  memory_game_pkg::card_addr_t click_addr,
    output logic                        deal_req,
    input  logic                        deal_ack,
    output memory_game_pkg::card_addr_t rd_addr,
    input  memory_game_pkg::card_t      rd_data,
    output logic                        game_we,
    output memory_game_pkg::card_addr_t game_addr,
    output memory_game_pkg::card_t      game_data,
    output logic [3:0]                  pairs_found,
    output logic                        game_done
);
    import memory_game_pkg::*;

    typedef enum logic [2:0] {
        DEAL,
        WAIT_FIRST,
        WAIT_SECOND,
        COMPARE,
        SHOW,
        HIDE_A,
        HIDE_B,
        DONE
    } game_state_t;

    game_state_t state;
    card_addr_t  addr_a;
    card_addr_t  addr_b;
    color_idx_t  color_a;
    color_idx_t  color_b;
    logic        keep_pair;
    logic        vsync_d;
    logic        frame_tick;
    logic [3:0]  show_cnt;
    logic        accept;
    logic        releasing;

    assign frame_tick = vsync && !vsync_d;
    assign releasing  = (state == HIDE_A) || (state == HIDE_B);

    // Only a hidden card can be turned
    assign accept = click && (rd_data.state == CARD_HIDDEN)
                 && ((state == WAIT_FIRST) || (state == WAIT_SECOND));

    //////////////////////////////
    // Store access
    //////////////////////////////

    always_comb begin
        case (state)
            HIDE_A:  rd_addr = addr_a;
            HIDE_B:  rd_addr = addr_b;
            default: rd_addr = click_addr;
        endcase
    end

    // Release step keeps a matched pair face up
    assign game_we         = accept || releasing;
    assign game_addr       = rd_addr;
    assign game_data.color = rd_data.color;
    assign game_data.state = !releasing ? CARD_SHOWN
                           : keep_pair  ? CARD_MATCHED : CARD_HIDDEN;

    //////////////////////////////
    // Game rules
    //////////////////////////////

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state       <= DEAL;
            deal_req    <= 1'b0;
            pairs_found <= '0;
            keep_pair   <= 1'b0;
            show_cnt    <= '0;
            vsync_d     <= 1'b0;
        end else begin
            vsync_d <= vsync;
            case (state)
                DEAL: begin
                    if (deal_ack) begin
                        deal_req <= 1'b0;
                        state    <= WAIT_FIRST;
                    end else begin
                        deal_req <= 1'b1;
                    end
                end
                WAIT_FIRST: begin
                    if (accept) begin
                        addr_a  <= click_addr;
                        color_a <= rd_data.color;
                        state   <= WAIT_SECOND;
                    end
                end
                WAIT_SECOND: begin
                    if (accept) begin
                        addr_b  <= click_addr;
                        color_b <= rd_data.color;
                        state   <= COMPARE;
                    end
                end
                COMPARE: begin
                    show_cnt <= '0;
                    if (color_a == color_b) begin
                        keep_pair   <= 1'b1;
                        pairs_found <= pairs_found + 4'd1;
                        state       <= HIDE_A;
                    end else begin
                        keep_pair <= 1'b0;
                        state     <= SHOW;
                    end
                end
                SHOW: begin
                    if (frame_tick) begin
                        show_cnt <= show_cnt + 4'd1;
                        if (show_cnt == `SHOW_FRAMES - 1) begin
                            state <= HIDE_A;
                        end
                    end
                end
                HIDE_A: state <= HIDE_B;
                HIDE_B: state <= (pairs_found == 4'd8) ? DONE : WAIT_FIRST;
                DONE:   state <= DONE;
                default: state <= DEAL;
            endcase
        end
    end

    // Stays set until reset
    assign game_done = (state == DONE);

endmodule

//--- logic/draw_cards.sv
`timescale 1ns/100ps

`include "memory_game_consts.svh"

module draw_cards (
    input  logic                        clk,
    input  logic                        rst_n,
    vga_bus_if.snk                      vga_in,
    output logic                        hs,
    output logic                        vs,
    output memory_game_pkg::rgb_t       rgb,
    output memory_game_pkg::card_addr_t rd_addr,
    input  memory_game_pkg::card_t      rd_data,
    input  logic [11:0]                 mouse_xpos,
    input  logic [11:0]                 mouse_ypos,
    input  logic                        mouse_left,
    output logic                        click,
    output memory_game_pkg::card_addr_t click_addr
);
    import memory_game_pkg::*;

    logic [4:0] pix_loc;
    logic [4:0] mouse_loc;
    logic       left_d;

    // Returns {inside, row, col} for a screen point
    function automatic logic [4:0] locate(input logic [11:0] x, input logic [11:0] y);
        logic [1:0] col;
        logic [1:0] row;
        logic       hit_x;
        logic       hit_y;
        col   = '0;
        row   = '0;
        hit_x = 1'b0;
        hit_y = 1'b0;
        for (int c = 0; c < `CARD_COLS; c++) begin
            if (x >= 12'(`BOARD_X + c * (`CARD_W + `CARD_GAP))
                    && x < 12'(`BOARD_X + c * (`CARD_W + `CARD_GAP) + `CARD_W)) begin
                col   = 2'(c);
                hit_x = 1'b1;
            end
        end
        for (int r = 0; r < `CARD_ROWS; r++) begin
            if (y >= 12'(`BOARD_Y + r * (`CARD_H + `CARD_GAP))
                    && y < 12'(`BOARD_Y + r * (`CARD_H + `CARD_GAP) + `CARD_H)) begin
                row   = 2'(r);
                hit_y = 1'b1;
            end
        end
        return {hit_x && hit_y, row, col};
    endfunction

    //////////////////////////////
    // Card painting
    //////////////////////////////

    assign pix_loc = locate({1'b0, vga_in.hcount}, {1'b0, vga_in.vcount});
    assign rd_addr = pix_loc[3:0];

    // Syncs go through the same stage as the colour
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            hs  <= 1'b0;
            vs  <= 1'b0;
            rgb <= '0;
        end else begin
            hs <= vga_in.hsync;
            vs <= vga_in.vsync;
            if (vga_in.hblnk || vga_in.vblnk) begin
                rgb <= '0;
            end else if (!pix_loc[4]) begin
                rgb <= vga_in.rgb;
            end else if (rd_data.state == CARD_HIDDEN) begin
                rgb <= HIDDEN_RGB;
            end else begin
                rgb <= CARD_PALETTE[rd_data.color];
            end
        end
    end

    //////////////////////////////
    // Mouse hit test
    //////////////////////////////

    assign mouse_loc = locate(mouse_xpos, mouse_ypos);

    // New press only, holding the button does nothing
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            left_d <= 1'b0;
            click  <= 1'b0;
        end else begin
            left_d <= mouse_left;
            click  <= mouse_left && !left_d && mouse_loc[4];
        end
    end

    always_ff @(posedge clk) begin
        click_addr <= mouse_loc[3:0];
    end

endmodule

//--- logic/memory_game_top.sv
`timescale 1ns/100ps

module memory_game_top (
    input  logic        clk,
    input  logic        rst_n,
    input  logic [11:0] mouse_xpos,
    input  logic [11:0] mouse_ypos,
    input  logic        mouse_left,
    output logic        hs,
    output logic        vs,
    output logic [3:0]  r,
    output logic [3:0]  g,
    output logic [3:0]  b,
    output logic [3:0]  pairs_found,
    output logic        game_done
);
    import memory_game_pkg::*;

    logic       deal_req;
    logic       deal_ack;
    logic       deal_we;
    logic       game_we;
    logic       click;
    card_addr_t deal_addr;
    card_addr_t game_addr;
    card_addr_t rd_a_addr;
    card_addr_t rd_b_addr;
    card_addr_t click_addr;
    card_t      deal_data;
    card_t      game_data;
    card_t      rd_a_data;
    card_t      rd_b_data;
    rgb_t       rgb;

    vga_bus_if vga ();

    vga_timing mg_timing (
        .clk   (clk),
        .rst_n (rst_n),
        .vga   (vga)
    );

    card_deal mg_deal (
        .clk       (clk),
        .rst_n     (rst_n),
        .deal_req  (deal_req),
        .deal_ack  (deal_ack),
        .deal_we   (deal_we),
        .deal_addr (deal_addr),
        .deal_data (deal_data)
    );

    card_store mg_store (
        .clk       (clk),
        .deal_we   (deal_we),
        .deal_addr (deal_addr),
        .deal_data (deal_data),
        .game_we   (game_we),
        .game_addr (game_addr),
        .game_data (game_data),
        .rd_a_addr (rd_a_addr),
        .rd_a_data (rd_a_data),
        .rd_b_addr (rd_b_addr),
        .rd_b_data (rd_b_data)
    );

    // Show timer counts frames from the raw bus
    game_fsm mg_fsm (
        .clk         (clk),
        .rst_n       (rst_n),
        .vsync       (vga.vsync),
        .click       (click),
        .click_addr  (click_addr),
        .deal_req    (deal_req),
        .deal_ack    (deal_ack),
        .rd_addr     (rd_b_addr),
        .rd_data     (rd_b_data),
        .game_we     (game_we),
        .game_addr   (game_addr),
        .game_data   (game_data),
        .pairs_found (pairs_found),
        .game_done   (game_done)
    );

    draw_cards mg_draw (
        .clk        (clk),
        .rst_n      (rst_n),
        .vga_in     (vga),
        .hs         (hs),
        .vs         (vs),
        .rgb        (rgb),
        .rd_addr    (rd_a_addr),
        .rd_data    (rd_a_data),
        .mouse_xpos (mouse_xpos),
        .mouse_ypos (mouse_ypos),
        .mouse_left (mouse_left),
        .click      (click),
        .click_addr (click_addr)
    );

    assign r = rgb[11:8];
    assign g = rgb[7:4];
    assign b = rgb[3:0];

endmodule

//--- test/memory_game_assertions.sv
`timescale 1ns/100ps

`include "memory_game_consts.svh"

module memory_game_assertions (
    input logic       clk,
    input logic       rst_n,
    input logic       deal_req,
    input logic       deal_ack,
    input logic [3:0] pairs_found,
    input logic       game_done
);

    localparam int ALL_PAIRS = `CARD_COLS * `CARD_ROWS / 2;

    // Four-phase deal handshake
    req_waits_for_ack_low: assert property (
        @(posedge clk) disable iff (!rst_n)
        $rose(deal_req) |-> !$past(deal_ack)
    ) else $error("deal_req raised while deal_ack was still high");

    // Pair counter only climbs, up to a full board
    pairs_climb_to_limit: assert property (
        @(posedge clk) disable iff (!rst_n)
        (pairs_found >= $past(pairs_found)) && (pairs_found <= 4'(ALL_PAIRS))
    ) else $error("pairs_found went down or past the number of pairs");

    done_only_when_all_found: assert property (
        @(posedge clk) disable iff (!rst_n)
        game_done |-> (pairs_found == 4'(ALL_PAIRS))
    ) else $error("game_done high before all pairs were found");

endmodule

bind game_fsm memory_game_assertions fsm_checks (
    .clk         (clk),
    .rst_n       (rst_n),
    .deal_req    (deal_req),
    .deal_ack    (deal_ack),
    .pairs_found (pairs_found),
    .game_done   (game_done)
);

//--- test/memory_game_tb.sv
`timescale 1ns/100ps

`include "memory_game_consts.svh"

module memory_game_tb;
    import memory_game_pkg::*;

    localparam int CLK_PERIOD   = 4;
    localparam int RESET_CYCLES = 10;
    localparam int FRAME_CYCLES = `H_TOTAL * `V_TOTAL;
    // Several times the frames the tests need
    localparam int WATCHDOG_FRAMES = 60;
    localparam longint WATCHDOG_NS = longint'(WATCHDOG_FRAMES) * FRAME_CYCLES * CLK_PERIOD;

    logic        clk = 1'b0;
    logic        rst_n;
    logic [11:0] mouse_xpos;
    logic [11:0] mouse_ypos;
    logic        mouse_left;
    logic        hs;
    logic        vs;
    logic [3:0]  r;
    logic [3:0]  g;
    logic [3:0]  b;
    logic [3:0]  pairs_found;
    logic        game_done;

    int          seed = 65889;
    int          fail_count = 0;
    card_state_t model_state [16];
    color_idx_t  model_color [16];

    // Pixel currently on the output pins
    int          pix_h = 0;
    int          pix_v = 0;
    logic        vs_last = 1'b0;
    logic        check_req = 1'b0;
    logic        checking = 1'b0;

    memory_game_top uut (
        .clk         (clk),
        .rst_n       (rst_n),
        .mouse_xpos  (mouse_xpos),
        .mouse_ypos  (mouse_ypos),
        .mouse_left  (mouse_left),
        .hs          (hs),
        .vs          (vs),
        .r           (r),
        .g           (g),
        .b           (b),
        .pairs_found (pairs_found),
        .game_done   (game_done)
    );

    always #(CLK_PERIOD / 2) clk = ~clk;

    //////////////////////////////
    // Reference model
    //////////////////////////////

    // Pairs in order and then 16 LFSR driven swaps from slot 15 down
    function automatic int deal_color(input int slot);
        int          board [16];
        logic [15:0] lfsr;
        logic        feedback;
        int          j;
        int          tmp;
        for (int i = 0; i < 16; i++) begin
            board[i] = i / 2;
        end
        lfsr = `DEAL_SEED;
        for (int k = 15; k >= 0; k--) begin
            feedback = lfsr[15] ^ lfsr[13] ^ lfsr[12] ^ lfsr[10];
            lfsr     = {lfsr[14:0], feedback};
            j        = int'(lfsr[3:0]);
            tmp      = board[k];
            board[k] = board[j];
            board[j] = tmp;
        end
        return board[slot];
    endfunction

    function automatic rgb_t expected_rgb(input int h, input int v);
        int x;
        int y;
        int n;
        x = h - `BOARD_X;
        y = v - `BOARD_Y;
        if (x < 0 || y < 0 || x >= `CARD_COLS * (`CARD_W + `CARD_GAP)
                || y >= `CARD_ROWS * (`CARD_H + `CARD_GAP)) begin
            return BACKGROUND_RGB;
        end
        if (x % (`CARD_W + `CARD_GAP) >= `CARD_W || y % (`CARD_H + `CARD_GAP) >= `CARD_H) begin
            return BACKGROUND_RGB;
        end
        n = (y / (`CARD_H + `CARD_GAP)) * `CARD_COLS + x / (`CARD_W + `CARD_GAP);
        if (model_state[n] == CARD_HIDDEN) begin
            return HIDDEN_RGB;
        end
        return CARD_PALETTE[model_color[n]];
    endfunction

    function automatic int partner_of(input int n);
        for (int i = 0; i < 16; i++) begin
            if (i != n && model_color[i] == model_color[n]) begin
                return i;
            end
        end
        return n;
    endfunction

    function automatic int rand_below(input int n);
        return int'($unsigned($random(seed)) % n);
    endfunction

    task automatic deal_model;
        for (int n = 0; n < 16; n++) begin
            model_color[n] = color_idx_t'(deal_color(n));
            model_state[n] = CARD_HIDDEN;
        end
    endtask

    //////////////////////////////
    // Checking
    //////////////////////////////

    task automatic end_with_failure;
        $display("Simulation finished: FAIL");
        $fatal(1, "run stopped at the first error");
    endtask

    task automatic expect_equal(input int actual, input int expected, input string what);
        if (actual != expected) begin
            fail_count++;
            $display("MISMATCH at %0d ns: %s, got 0x%0h, expected 0x%0h",
                     $time, what, actual, expected);
            end_with_failure();
        end
    endtask

    // Each vs rise puts the output at pixel 0 of line V_SYNC_START
    always @(negedge clk) begin : compare_pixels
        if (vs === 1'b1 && vs_last === 1'b0) begin
            pix_h = 0;
            pix_v = `V_SYNC_START;
        end else if (pix_h == `H_TOTAL - 1) begin
            pix_h = 0;
            pix_v = (pix_v == `V_TOTAL - 1) ? 0 : pix_v + 1;
        end else begin
            pix_h = pix_h + 1;
        end
        vs_last = vs;
        if (check_req && pix_h == 0 && pix_v == 0) begin
            checking = 1'b1;
        end
        if (checking && pix_h < `H_ACTIVE && pix_v < `V_ACTIVE) begin
            expect_equal(int'({r, g, b}), int'(expected_rgb(pix_h, pix_v)),
                         $sformatf("colour at pixel %0d, line %0d", pix_h, pix_v));
        end
        if (checking && pix_h == `H_ACTIVE - 1 && pix_v == `V_ACTIVE - 1) begin
            checking  = 1'b0;
            check_req = 1'b0;
        end
    end

    // Whole next frame against the model
    task automatic verify_next_frame;
        @(posedge clk);
        check_req = 1'b1;
        wait (check_req == 1'b0);
    endtask

    task automatic measure_sync;
        time t_rise;
        time t_fall;
        time t_next;
        @(posedge hs);
        t_rise = $time;
        @(negedge hs);
        t_fall = $time;
        @(posedge hs);
        t_next = $time;
        expect_equal(int'((t_fall - t_rise) / CLK_PERIOD), `H_SYNC_END - `H_SYNC_START,
                     "hs pulse width in clocks");
        expect_equal(int'((t_next - t_rise) / CLK_PERIOD), `H_TOTAL, "hs period in clocks");
        @(posedge vs);
        t_rise = $time;
        @(negedge vs);
        t_fall = $time;
        @(posedge vs);
        t_next = $time;
        expect_equal(int'((t_fall - t_rise) / CLK_PERIOD),
                     `H_TOTAL * (`V_SYNC_END - `V_SYNC_START), "vs pulse width in clocks");
        expect_equal(int'((t_next - t_rise) / CLK_PERIOD), FRAME_CYCLES, "vs period in clocks");
    endtask

    //////////////////////////////
    // Stimulus
    //////////////////////////////

    task automatic apply_reset;
        @(negedge clk);
        rst_n      = 1'b0;
        mouse_left = 1'b0;
        repeat (RESET_CYCLES) @(negedge clk);
        expect_equal(int'({hs, vs, r, g, b}), 0, "hs, vs and rgb in reset");
        expect_equal(int'({uut.deal_req, uut.deal_ack, uut.click}), 0,
                     "deal_req, deal_ack and click in reset");
        expect_equal(int'(pairs_found), 0, "pairs_found in reset");
        expect_equal(int'(game_done), 0, "game_done in reset");
        rst_n = 1'b1;
        // Deal handshake marks the board as ready
        wait (uut.deal_ack === 1'b1);
        wait (uut.deal_ack === 1'b0);
    endtask

    task automatic click_at(input int x, input int y);
        @(negedge clk);
        mouse_xpos = 12'(x);
        mouse_ypos = 12'(y);
        mouse_left = 1'b1;
        repeat (3) @(negedge clk);
        mouse_left = 1'b0;
        repeat (3) @(negedge clk);
    endtask

    task automatic click_card(input int n);
        int x;
        int y;
        x = `BOARD_X + (n % `CARD_COLS) * (`CARD_W + `CARD_GAP) + rand_below(`CARD_W);
        y = `BOARD_Y + (n / `CARD_COLS) * (`CARD_H + `CARD_GAP) + rand_below(`CARD_H);
        click_at(x, y);
    endtask

    task automatic play_pair(input int first, input int second);
        click_card(first);
        click_card(second);
        if (model_color[first] == model_color[second]) begin
            model_state[first]  = CARD_MATCHED;
            model_state[second] = CARD_MATCHED;
        end else begin
            model_state[first]  = CARD_SHOWN;
            model_state[second] = CARD_SHOWN;
        end
    endtask

    initial begin : watchdog
        #(WATCHDOG_NS);
        $display("ERROR: watchdog expired after %0d frame times, the DUT stopped responding",
                 WATCHDOG_FRAMES);
        end_with_failure();
    end

    initial begin : stimulus
        int first;
        int second;
        int c;
        int x;
        int y;
        rst_n      = 1'b0;
        mouse_xpos = '0;
        mouse_ypos = '0;
        mouse_left = 1'b0;
        deal_model();
        apply_reset();
        measure_sync();
        verify_next_frame();

        // Gaps and outside the board
        for (int i = 0; i < 4; i++) begin
            c = rand_below(`CARD_COLS - 1);
            x = `BOARD_X + c * (`CARD_W + `CARD_GAP) + `CARD_W + rand_below(`CARD_GAP);
            click_at(x, rand_below(`V_ACTIVE));
            c = rand_below(`CARD_ROWS - 1);
            y = `BOARD_Y + c * (`CARD_H + `CARD_GAP) + `CARD_H + rand_below(`CARD_GAP);
            click_at(rand_below(`H_ACTIVE), y);
        end
        click_at(rand_below(`BOARD_X), rand_below(`V_ACTIVE));
        click_at(`H_ACTIVE - 1 - rand_below(4), rand_below(`V_ACTIVE));
        click_at(rand_below(`H_ACTIVE), `V_ACTIVE - 1 - rand_below(4));

        // Press in a gap and slide onto card 0 with the button held
        @(negedge clk);
        mouse_xpos = 12'(`BOARD_X + `CARD_W);
        mouse_ypos = 12'(`BOARD_Y);
        mouse_left = 1'b1;
        repeat (4) @(negedge clk);
        mouse_xpos = 12'(`BOARD_X + 1);
        repeat (4) @(negedge clk);
        mouse_left = 1'b0;
        verify_next_frame();
        expect_equal(int'(pairs_found), 0, "pairs_found after ignored clicks");

        // Mismatched pair clicked just after a frame tick
        first  = 0;
        second = 1;
        while (model_color[second] == model_color[first]) begin
            second++;
        end
        @(posedge vs);
        play_pair(first, second);
        // Face up for SHOW_FRAMES whole frames
        for (int f = 0; f < `SHOW_FRAMES; f++) begin
            verify_next_frame();
        end
        @(posedge vs);
        model_state[first]  = CARD_HIDDEN;
        model_state[second] = CARD_HIDDEN;
        verify_next_frame();
        expect_equal(int'(pairs_found), 0, "pairs_found after a mismatch");

        // Matching pair and a click on a matched card
        second = partner_of(first);
        play_pair(first, second);
        verify_next_frame();
        expect_equal(int'(pairs_found), 1, "pairs_found after the first match");
        click_card(second);
        verify_next_frame();
        expect_equal(int'(pairs_found), 1, "pairs_found after clicking a matched card");

        for (int n = 0; n < 16; n++) begin
            if (model_state[n] == CARD_HIDDEN) begin
                play_pair(n, partner_of(n));
            end
        end
        wait (game_done === 1'b1);
        expect_equal(int'(pairs_found), 8, "pairs_found at game end");
        verify_next_frame();
        click_card(rand_below(16));
        click_at(`BOARD_X + `CARD_W, `BOARD_Y);
        verify_next_frame();
        expect_equal(int'({game_done, pairs_found}), 'h18, "game_done and pairs_found held");

        // New game after reset
        apply_reset();
        deal_model();
        @(posedge vs);
        verify_next_frame();
        expect_equal(int'({game_done, pairs_found}), 0, "game_done and pairs_found after reset");

        if (fail_count == 0) begin
            $display("Simulation finished: PASS");
        end else begin
            $display("Simulation finished: FAIL");
        end
        $finish;
    end

endmodule

//--- project.f
+incdir+logic
logic/memory_game_pkg.sv
logic/vga_bus_if.sv
logic/vga_timing.sv
logic/card_deal.sv
logic/card_store.sv
logic/game_fsm.sv
logic/draw_cards.sv
logic/memory_game_top.sv
test/memory_game_assertions.sv
test/memory_game_tb.sv

//--- Makefile
# Verilator build and run of the memory game testbench

VERILATOR ?= verilator
TOP       ?= memory_game_tb
FILELIST  ?= project.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -Wno-fatal
FAIL_MSG  := Simulation finished: FAIL
SOURCES   := $(wildcard logic/*.sv logic/*.svh test/*.sv)

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run the testbench and check $(LOG)"
	@echo "  clean  remove $(BUILD_DIR) and $(LOG)"
	@echo "Variables: VERILATOR TOP FILELIST BUILD_DIR LOG VFLAGS"

$(BUILD_DIR)/V$(TOP): $(FILELIST) $(SOURCES)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

test: $(BUILD_DIR)/V$(TOP)
	@./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1; status=$$?; cat $(LOG); \
	if [ $$status -ne 0 ] || grep -q "$(FAIL_MSG)" $(LOG); then \
		echo "test: failed, see $(LOG)"; exit 1; \
	else \
		echo "test: passed"; \
	fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)
